/* sources.f */
hdl/matrix_pkg.sv
hdl/countdown_seq.sv
hdl/row_scan.sv
hdl/glyph_render.sv
hdl/matrix_top.sv
testbench/tb_matrix_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_matrix_top > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_matrix_top > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/tb_matrix_top.sv */
`default_nettype none

module tb_matrix_top;
    import matrix_pkg::*;

    localparam int TICK_DIV       = 64;
    localparam int SCAN_DIV       = 4;
    localparam int NUM_RUNS       = 12;
    localparam int TIMEOUT_CYCLES = 30 * 6 * TICK_DIV + 1000; // 30 full countdowns plus margin

    logic        clk;
    logic        rst;
    logic        start;
    logic        pause;
    matrix_out_t disp;
    logic        done;

    integer      seed;
    int          runs;
    int          gap_left;
    int          pause_left;
    logic        wait_done;
    logic        finished;
    int          cycle_count = 0;

    // reference model state
    digit_t      m_digit;
    logic        m_visible;
    logic        m_done = 1'b0;
    int          m_tick;
    int          m_div;
    row_idx_t    m_row;
    matrix_out_t exp_disp = '0;
    int          live_edges = 0;

    // row scan observation
    row_bits_t   last_row = '0;
    int          dwell = 0;

    int          done_rises = 0;
    int          restarts_mid = 0;
    int          restarts_after_done = 0;
    int          pause_holds = 0;

    matrix_top #(
        .TICK_DIV (TICK_DIV),
        .SCAN_DIV (SCAN_DIV)
    ) UUT (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .pause (pause),
        .disp  (disp),
        .done  (done)
    );

    always #20 clk = ~clk;

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
                               name, actual, expected));
        end
    endtask

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // red for 5 and 4, both planes for 3 and 2, green for 1 and 0
    function automatic matrix_out_t predict_disp(input digit_t d, input logic vis,
                                                 input row_idx_t r);
        matrix_out_t m;
        row_bits_t   pattern;
        pattern = glyph_row(d, r);
        m.row   = 8'b0000_0001 << r;
        m.colr  = '0;
        m.colg  = '0;
        if (vis)
        begin
            if (d >= 3'd4)
            begin
                m.colr = pattern;
            end
            else if (d >= 3'd2)
            begin
                m.colr = pattern;
                m.colg = pattern;
            end
            else
            begin
                m.colg = pattern;
            end
        end
        return m;
    endfunction

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            fail_now($sformatf("timeout: the run went past %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // inputs read here are the values the DUT samples at this edge
    always @(posedge clk)
    begin
        if (rst)
        begin
            exp_disp   = '0;
            m_digit    = 3'd0;
            m_visible  = 1'b0;
            m_done     = 1'b0;
            m_tick     = 0;
            m_div      = 0;
            m_row      = 3'd0;
            live_edges = 0;
        end
        else
        begin
            exp_disp   = predict_disp(m_digit, m_visible, m_row); // one cycle of latency
            live_edges = live_edges + 1;
            if (start)
            begin
                if (m_visible && m_digit != 3'd0)
                    restarts_mid = restarts_mid + 1;
                if (m_done)
                    restarts_after_done = restarts_after_done + 1;
                m_tick    = 0;
                m_digit   = START_DIGIT;
                m_visible = 1'b1;
                m_done    = 1'b0;
            end
            else if (m_visible && m_digit != 3'd0)
            begin
                if (pause)
                begin
                    pause_holds = pause_holds + 1; // tick and digit frozen
                end
                else if (m_tick == TICK_DIV - 1)
                begin
                    m_tick  = 0;
                    m_digit = m_digit - 3'd1;
                    if (m_digit == 3'd0)
                    begin
                        m_done     = 1'b1;
                        done_rises = done_rises + 1;
                    end
                end
                else
                begin
                    m_tick = m_tick + 1;
                end
            end
            if (m_div == SCAN_DIV - 1)
            begin
                m_div = 0;
                m_row = m_row + 3'd1;
            end
            else
            begin
                m_div = m_div + 1;
            end
        end
    end

    always @(negedge clk)
    begin
        check_value("disp.row", 32'(disp.row), 32'(exp_disp.row));
        check_value("disp.colr", 32'(disp.colr), 32'(exp_disp.colr));
        check_value("disp.colg", 32'(disp.colg), 32'(exp_disp.colg));
        check_value("done", 32'(done), 32'(m_done));
        if (live_edges > 0)
            check_value("disp.row ones", 32'($countones(disp.row)), 32'd1);
        if (disp.row != last_row)
        begin
            if ($countones(last_row) == 1)
            begin
                check_value("disp.row next", 32'(disp.row), 32'({last_row[6:0], last_row[7]}));
                check_value("row dwell", 32'(dwell), 32'(SCAN_DIV));
            end
            dwell    = 1;
            last_row = disp.row;
        end
        else
        begin
            dwell = dwell + 1;
        end
    end

    initial
    begin
        seed       = 32'hca80_ea9e;
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        pause      = 1'b0;
        runs       = 0;
        pause_left = 0;
        wait_done  = 1'b0;
        finished   = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        gap_left = 16 + pick(32); // blank matrix before the first start
        while (!finished)
        begin
            @(posedge clk);
            if (pause_left > 0)
            begin
                pause_left = pause_left - 1;
                pause <= 1'b1;
            end
            else if (pick(64) == 0)
            begin
                pause_left = pick(32);
                pause <= 1'b1;
            end
            else
            begin
                pause <= 1'b0;
            end

            start <= 1'b0;
            if (gap_left > 0)
            begin
                gap_left = gap_left - 1;
            end
            else if (wait_done)
            begin
                if (done)
                begin
                    wait_done = 1'b0;
                    gap_left  = pick(16);
                end
            end
            else if (runs < NUM_RUNS)
            begin
                start <= 1'b1;
                runs      = runs + 1;
                wait_done = (pick(3) != 0); // otherwise restart in the middle of a count
                gap_left  = wait_done ? 2 : 1 + pick(250);
            end
            else
            begin
                finished = 1'b1;
            end
        end
        repeat (4) @(posedge clk);
        if (done_rises == 0 || restarts_mid == 0 || restarts_after_done == 0 ||
            pause_holds == 0)
        begin
            fail_now("stimulus never reached done, a restart or a pause during a count");
        end
        else
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hdl/matrix_top.sv */
`default_nettype none

module matrix_top #(
    parameter int TICK_DIV = 64,
    parameter int SCAN_DIV = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    pause,
    output matrix_pkg::matrix_out_t disp,
    output logic                    done
);
    import matrix_pkg::*;

    show_t    show;
    row_idx_t row_idx;
    logic     row_step;

    countdown_seq #(
        .TICK_DIV (TICK_DIV)
    ) u_countdown_seq (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .pause (pause),
        .show  (show),
        .done  (done)
    );

    // scan runs free of the countdown
    row_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) u_row_scan (
        .clk      (clk),
        .rst      (rst),
        .row_idx  (row_idx),
        .row_step (row_step)
    );

    glyph_render u_glyph_render (
        .clk      (clk),
        .rst      (rst),
        .show     (show),
        .row_idx  (row_idx),
        .row_step (row_step),
        .disp     (disp)
    );

endmodule

`default_nettype wire

/* hdl/glyph_render.sv */
`default_nettype none

module glyph_render (
    input  logic                    clk,
    input  logic                    rst,
    input  matrix_pkg::show_t       show,
    input  matrix_pkg::row_idx_t    row_idx,
    input  logic                    row_step,
    output matrix_pkg::matrix_out_t disp
);
    import matrix_pkg::*;

    row_bits_t row_sel;
    row_bits_t pattern;
    row_bits_t red_cols;
    row_bits_t green_cols;
    logic      red_on;
    logic      green_on;

    always_comb
    begin
        row_sel = 8'b0000_0001 << row_idx;
        pattern = glyph_row(show.digit, row_idx);

        // yellow drives both planes with the same pattern
        red_on   = show.visible &&
                   (show.color == color_red || show.color == color_yellow);
        green_on = show.visible &&
                   (show.color == color_green || show.color == color_yellow);

        red_cols   = red_on   ? pattern : '0;
        green_cols = green_on ? pattern : '0;
    end

    // row select and columns share one register stage so they never skew
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            disp <= '0;
        end
        else
        begin
            disp.row  <= row_sel;
            disp.colr <= red_cols;
            disp.colg <= green_cols;
        end
    end

    a_row_onehot: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(disp.row)
    );

    // the rendered row trails the scanner by one cycle
    a_row_on_step: assert property (
        @(posedge clk) disable iff (rst)
        $changed(disp.row) && $onehot($past(disp.row)) |-> $past(row_step)
    );

endmodule

`default_nettype wire

/* hdl/row_scan.sv */
`default_nettype none

module row_scan #(
    parameter int SCAN_DIV = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    output matrix_pkg::row_idx_t row_idx,
    output logic                 row_step
);

    localparam int SW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [SW-1:0] SCAN_LAST = SW'(SCAN_DIV - 1);

    logic [SW-1:0] div_q;
    logic          wrap;

    assign wrap = (div_q == SCAN_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_q    <= '0;
            row_idx  <= 3'd0;
            row_step <= 1'b0;
        end
        else
        begin
            row_step <= wrap;  // high while the new row is first presented
            if (wrap)
            begin
                div_q   <= '0;
                row_idx <= row_idx + 3'd1; // 7 rolls over to 0
            end
            else
            begin
                div_q <= div_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/countdown_seq.sv */
`default_nettype none

module countdown_seq #(
    parameter int TICK_DIV = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              pause,
    output matrix_pkg::show_t show,
    output logic              done
);
    import matrix_pkg::*;

    localparam int TW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [TW-1:0] TICK_LAST = TW'(TICK_DIV - 1);

    logic [TW-1:0] tick_q;
    digit_t        digit_q;
    logic          visible_q;
    logic          running;
    logic          step;

    // divider only counts while there is something left to count down
    assign running = visible_q && !pause && (digit_q != 3'd0);
    assign step    = running && (tick_q == TICK_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tick_q    <= '0;
            digit_q   <= 3'd0;
            visible_q <= 1'b0;
            done      <= 1'b0;
        end
        else if (start)
        begin
            tick_q    <= '0;          // restart wins over a pending step
            digit_q   <= START_DIGIT;
            visible_q <= 1'b1;
            done      <= 1'b0;
        end
        else if (step)
        begin
            tick_q  <= '0;
            digit_q <= digit_q - 3'd1;
            done    <= (digit_q == 3'd1); // rises with the 0 digit
        end
        else if (running)
        begin
            tick_q <= tick_q + 1'b1;
        end
    end

    assign show.digit   = digit_q;
    assign show.color   = visible_q ? digit_color(digit_q) : color_off;
    assign show.visible = visible_q;

    a_digit_range: assert property (
        @(posedge clk) disable iff (rst)
        digit_q <= START_DIGIT
    );

    // once finished, only a new start leaves the 0 digit
    a_done_holds: assert property (
        @(posedge clk) disable iff (rst)
        done && !start |=> done && (show.digit == 3'd0)
    );

endmodule

`default_nettype wire

/* hdl/matrix_pkg.sv */
`default_nettype none

package matrix_pkg;

    typedef logic [2:0] digit_t;    // countdown value, 0 to 5
    typedef logic [2:0] row_idx_t;  // scan row, 0 to 7
    typedef logic [7:0] row_bits_t; // one bit per column, msb is the left column

    // yellow is red and green lit together, so its code is the or of both
    typedef enum logic [1:0] {
        color_off    = 2'b00,
        color_red    = 2'b01,
        color_green  = 2'b10,
        color_yellow = 2'b11
    } disp_color_t;

    typedef struct packed {
        digit_t      digit;
        disp_color_t color;
        logic        visible;
    } show_t;

    typedef struct packed {
        row_bits_t row;  // one-hot row select
        row_bits_t colr;
        row_bits_t colg;
    } matrix_out_t;

    localparam digit_t START_DIGIT = 3'd5;

    // rows 1 to 6 are packed top to bottom, first row in the high byte
    function automatic row_bits_t glyph_row(input digit_t d, input row_idx_t r);
        logic [47:0] shape;
        int          idx;
        case (d)
            3'd5: shape = 48'h7E_60_7C_06_66_3C;
            3'd4: shape = 48'h0C_1C_2C_4C_7E_0C;
            3'd3: shape = 48'h3C_66_0C_06_66_3C;
            3'd2: shape = 48'h3C_66_0C_18_30_7E;
            3'd1: shape = 48'h18_38_18_18_18_3C;
            3'd0: shape = 48'h3C_66_6E_76_66_3C;
            default: shape = '0;
        endcase
        if (r == 3'd0 || r == 3'd7)
        begin
            return '0;  // border rows stay dark
        end
        idx = 6 - int'(r);
        return shape[idx*8 +: 8];
    endfunction

    function automatic disp_color_t digit_color(input digit_t d);
        case (d)
            3'd5, 3'd4: return color_red;
            3'd3, 3'd2: return color_yellow;
            3'd1, 3'd0: return color_green;
            default:    return color_off;
        endcase
    endfunction

endpackage

`default_nettype wire
